//--- flist.f
+incdir+hw
hw/noc_pkg.sv
hw/noc_ingress.sv
hw/noc_router.sv
hw/noc_pe.sv
hw/noc_egress.sv
hw/noc_star.sv
tests/noc_star_tb.sv

//--- hw/noc_cfg.svh
`ifndef NOC_CFG_SVH
`define NOC_CFG_SVH

// ------------------------------
// Flit payload
// ------------------------------
`define NOC_DATAW 32
`define NOC_LANES 4
`define NOC_LANEW 8

// ------------------------------
// Router ports and flit fields
// ------------------------------
// Port 0 is the host, ports 1 to 4 the elements
`define NOC_PORTS 5
`define NOC_DESTW 3
`define NOC_OPW 2

// Buffering, also the initial credits of each sender
`define NOC_BUF_DEPTH 4
`define NOC_EGRESS_DEPTH 4

`endif

//--- hw/noc_egress.sv
`include "noc_cfg.svh"

module noc_egress (
    input  logic                clk,
    input  logic                reset,

    // Link from router port 0
    input  noc_pkg::payload_u   flit_data,
    input  noc_pkg::flit_dest_t flit_src,
    input  noc_pkg::op_e        flit_op,
    input  logic                flit_send,
    output logic                flit_credit,

    // Host stream out
    output logic                m_tvalid,
    input  logic                m_tready,
    output noc_pkg::payload_u   m_tdata,
    output noc_pkg::flit_dest_t m_tdest,
    output noc_pkg::op_e        m_tuser
);
    import noc_pkg::*;

    localparam int PTRW = $clog2(`NOC_EGRESS_DEPTH);
    localparam int CNTW = $clog2(`NOC_EGRESS_DEPTH + 1);

    payload_u   mem_data [`NOC_EGRESS_DEPTH];
    flit_dest_t mem_src  [`NOC_EGRESS_DEPTH];
    op_e        mem_op   [`NOC_EGRESS_DEPTH];

    logic [PTRW-1:0] wr_ptr;
    logic [PTRW-1:0] rd_ptr;
    logic [CNTW-1:0] count;
    logic            pop;

    // Head of the buffer drives the stream directly
    assign m_tvalid = count != '0;
    assign m_tdata  = mem_data[rd_ptr];
    assign m_tdest  = mem_src[rd_ptr];
    assign m_tuser  = mem_op[rd_ptr];
    assign pop      = m_tvalid && m_tready;

    always_ff @(posedge clk) begin
        if (flit_send) begin
            mem_data[wr_ptr] <= flit_data;
            mem_src[wr_ptr]  <= flit_src;
            mem_op[wr_ptr]   <= flit_op;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            flit_credit <= 1'b0;
        end else begin
            wr_ptr      <= wr_ptr + PTRW'(flit_send);
            rd_ptr      <= rd_ptr + PTRW'(pop);
            count       <= count + CNTW'(flit_send) - CNTW'(pop);
            // One credit per word taken by the host
            flit_credit <= pop;
        end
    end

    a_hold_until_ready: assert property (@(posedge clk) disable iff (reset)
        m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata));

endmodule

//--- hw/noc_ingress.sv
`include "noc_cfg.svh"

module noc_ingress (
    input  logic                clk,
    input  logic                reset,

    // Host stream in
    input  logic                s_tvalid,
    output logic                s_tready,
    input  noc_pkg::payload_u   s_tdata,
    input  noc_pkg::flit_dest_t s_tdest,
    input  noc_pkg::op_e        s_tuser,

    // Link into router port 0
    output noc_pkg::payload_u   flit_data,
    output noc_pkg::flit_dest_t flit_dest,
    output noc_pkg::op_e        flit_op,
    output logic                flit_send,
    input  logic                flit_credit
);
    localparam int CNTW = $clog2(`NOC_BUF_DEPTH + 1);

    logic [CNTW-1:0] credit_cnt;
    logic [CNTW-1:0] credit_nxt;
    logic            accept;

    assign accept = s_tvalid && s_tready;

    // Credits left after this cycle's send and return
    always_comb begin
        credit_nxt = credit_cnt;
        if (accept) begin
            credit_nxt = credit_nxt - 1'b1;
        end
        if (flit_credit) begin
            credit_nxt = credit_nxt + 1'b1;
        end
    end

    // The output register always drains one cycle after the handshake,
    // so only the credit count decides ready
    always_ff @(posedge clk) begin
        if (reset) begin
            credit_cnt <= CNTW'(`NOC_BUF_DEPTH);
            s_tready   <= 1'b0;
            flit_send  <= 1'b0;
        end else begin
            credit_cnt <= credit_nxt;
            s_tready   <= credit_nxt != '0;
            flit_send  <= accept;
        end
    end

    // Flit register
    always_ff @(posedge clk) begin
        if (accept) begin
            flit_data <= s_tdata;
            flit_dest <= s_tdest;
            flit_op   <= s_tuser;
        end
    end

    // Router returns a credit only for a flit still out
    a_credit_not_full: assert property (@(posedge clk) disable iff (reset)
        flit_credit |-> credit_cnt != CNTW'(`NOC_BUF_DEPTH));

endmodule

//--- hw/noc_pe.sv
`include "noc_cfg.svh"

module noc_pe (
    input  logic                clk,
    input  logic                reset,

    // Link from router
    input  noc_pkg::payload_u   in_data,
    input  noc_pkg::op_e        in_op,
    input  logic                in_send,
    output logic                in_credit,

    // Link back to router
    output noc_pkg::payload_u   out_data,
    output noc_pkg::flit_dest_t out_dest,
    output noc_pkg::op_e        out_op,
    output logic                out_send,
    input  logic                out_credit
);
    import noc_pkg::*;

    localparam int PTRW = $clog2(`NOC_BUF_DEPTH);
    localparam int CNTW = $clog2(`NOC_BUF_DEPTH + 1);

    payload_u fifo_data [`NOC_BUF_DEPTH];
    op_e      fifo_op   [`NOC_BUF_DEPTH];

    logic [PTRW-1:0]       wr_ptr;
    logic [PTRW-1:0]       rd_ptr;
    logic [CNTW-1:0]       count;
    logic [CNTW-1:0]       credit_cnt;
    logic                  res_valid;
    logic                  take;
    payload_u              head;
    payload_u              result;
    logic [`NOC_DATAW-1:0] lane_sum;
    logic [`NOC_DATAW-1:0] acc;
    logic [`NOC_DATAW-1:0] acc_nxt;

    assign head     = fifo_data[rd_ptr];
    assign out_send = res_valid && credit_cnt != '0;
    assign take     = count != '0 && (!res_valid || out_send);
    assign out_dest = '0;

    // ------------------------------
    // Lane datapath
    // ------------------------------
    always_comb begin
        lane_sum = '0;
        for (int l = 0; l < `NOC_LANES; l++) begin
            lane_sum = lane_sum
                + {{(`NOC_DATAW-`NOC_LANEW){head.lanes[l][`NOC_LANEW-1]}}, head.lanes[l]};
        end
        acc_nxt = acc + lane_sum;

        result = head;
        case (fifo_op[rd_ptr])
            op_relu: begin
                for (int l = 0; l < `NOC_LANES; l++) begin
                    if (head.lanes[l][`NOC_LANEW-1]) begin
                        result.lanes[l] = '0;
                    end
                end
            end
            op_acc:  result.word = acc_nxt;
            default: result = head;
        endcase
    end

    always_ff @(posedge clk) begin
        if (in_send) begin
            fifo_data[wr_ptr] <= in_data;
            fifo_op[wr_ptr]   <= in_op;
        end
        // Result register, held until a router credit frees it
        if (take) begin
            out_data <= result;
            out_op   <= fifo_op[rd_ptr];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credit_cnt <= CNTW'(`NOC_BUF_DEPTH);
            res_valid  <= 1'b0;
            in_credit  <= 1'b0;
            acc        <= '0;
        end else begin
            wr_ptr     <= wr_ptr + PTRW'(in_send);
            rd_ptr     <= rd_ptr + PTRW'(take);
            count      <= count + CNTW'(in_send) - CNTW'(take);
            credit_cnt <= credit_cnt - CNTW'(out_send) + CNTW'(out_credit);
            in_credit  <= take;
            if (take) begin
                res_valid <= 1'b1;
            end else if (out_send) begin
                res_valid <= 1'b0;
            end
            if (take && fifo_op[rd_ptr] == op_acc) begin
                acc <= acc_nxt;
            end
        end
    end

endmodule

//--- hw/noc_pkg.sv
`include "noc_cfg.svh"

package noc_pkg;

    // One payload word, seen either whole or as signed byte lanes
    typedef union packed {
        logic [`NOC_DATAW-1:0] word;
        logic signed [`NOC_LANES-1:0][`NOC_LANEW-1:0] lanes;
    } payload_u;

    // Element operations; the fourth code behaves like op_pass
    typedef enum logic [`NOC_OPW-1:0] {
        op_pass = 2'd0,
        op_relu = 2'd1,
        op_acc  = 2'd2
    } op_e;

    // Router port index
    typedef logic [`NOC_DESTW-1:0] flit_dest_t;

endpackage

//--- hw/noc_router.sv
`include "noc_cfg.svh"

module noc_router (
    input  logic                                     clk,
    input  logic                                     reset,

    // Links from senders
    input  noc_pkg::payload_u   [`NOC_PORTS-1:0]     in_data,
    input  noc_pkg::flit_dest_t [`NOC_PORTS-1:0]     in_dest,
    input  noc_pkg::op_e        [`NOC_PORTS-1:0]     in_op,
    input  logic                [`NOC_PORTS-1:0]     in_send,
    output logic                [`NOC_PORTS-1:0]     in_credit,

    // Links to receivers
    output noc_pkg::payload_u   [`NOC_PORTS-1:0]     out_data,
    output noc_pkg::flit_dest_t [`NOC_PORTS-1:0]     out_dest,
    output noc_pkg::op_e        [`NOC_PORTS-1:0]     out_op,
    output logic                [`NOC_PORTS-1:0]     out_send,
    input  logic                [`NOC_PORTS-1:0]     out_credit,
    output noc_pkg::flit_dest_t [`NOC_PORTS-1:0]     out_src
);
    import noc_pkg::*;

    // Depth is a power of two, pointers wrap on their own
    localparam int PTRW = $clog2(`NOC_BUF_DEPTH);
    localparam int CNTW = $clog2(`NOC_BUF_DEPTH + 1);

    // ------------------------------
    // Input buffers
    // ------------------------------
    payload_u   buf_data [`NOC_PORTS][`NOC_BUF_DEPTH];
    flit_dest_t buf_dest [`NOC_PORTS][`NOC_BUF_DEPTH];
    op_e        buf_op   [`NOC_PORTS][`NOC_BUF_DEPTH];

    logic [PTRW-1:0] wr_ptr [`NOC_PORTS];
    logic [PTRW-1:0] rd_ptr [`NOC_PORTS];
    logic [CNTW-1:0] count  [`NOC_PORTS];

    // Per output state
    logic [CNTW-1:0] credit   [`NOC_PORTS];
    flit_dest_t      last_gnt [`NOC_PORTS];

    flit_dest_t            route   [`NOC_PORTS];
    logic [`NOC_PORTS-1:0] gnt     [`NOC_PORTS];
    flit_dest_t            gnt_src [`NOC_PORTS];
    logic [`NOC_PORTS-1:0] gnt_any;
    logic [`NOC_PORTS-1:0] pop;

    // Host flits go to their element, element flits go to the host
    always_comb begin
        for (int i = 0; i < `NOC_PORTS; i++) begin
            route[i] = (i == 0) ? buf_dest[i][rd_ptr[i]] : '0;
        end
    end

    // ------------------------------
    // Round-robin arbitration
    // ------------------------------
    always_comb begin
        int idx;
        pop = '0;
        for (int o = 0; o < `NOC_PORTS; o++) begin
            gnt[o]     = '0;
            gnt_any[o] = 1'b0;
            gnt_src[o] = '0;
            // Search starts just after the last winner
            for (int k = 1; k <= `NOC_PORTS; k++) begin
                idx = int'(last_gnt[o]) + k;
                if (idx >= `NOC_PORTS) begin
                    idx = idx - `NOC_PORTS;
                end
                if (!gnt_any[o] && count[idx] != '0 && route[idx] == o
                        && credit[o] != '0) begin
                    gnt[o][idx] = 1'b1;
                    gnt_any[o]  = 1'b1;
                    gnt_src[o]  = flit_dest_t'(idx);
                end
            end
            pop = pop | gnt[o];
        end
    end

    // Buffer storage
    always_ff @(posedge clk) begin
        for (int i = 0; i < `NOC_PORTS; i++) begin
            if (in_send[i]) begin
                buf_data[i][wr_ptr[i]] <= in_data[i];
                buf_dest[i][wr_ptr[i]] <= in_dest[i];
                buf_op[i][wr_ptr[i]]   <= in_op[i];
            end
        end
    end

    // Output flit registers; the host sees the source port as dest
    always_ff @(posedge clk) begin
        for (int o = 0; o < `NOC_PORTS; o++) begin
            if (gnt_any[o]) begin
                out_data[o] <= buf_data[gnt_src[o]][rd_ptr[gnt_src[o]]];
                out_op[o]   <= buf_op[gnt_src[o]][rd_ptr[gnt_src[o]]];
                out_dest[o] <= (o == 0) ? gnt_src[o] : buf_dest[gnt_src[o]][rd_ptr[gnt_src[o]]];
                out_src[o]  <= gnt_src[o];
            end
        end
    end

    // ------------------------------
    // Pointers, counts and credits
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int p = 0; p < `NOC_PORTS; p++) begin
                wr_ptr[p]   <= '0;
                rd_ptr[p]   <= '0;
                count[p]    <= '0;
                credit[p]   <= CNTW'(`NOC_BUF_DEPTH);
                last_gnt[p] <= '0;
            end
            out_send  <= '0;
            in_credit <= '0;
        end else begin
            for (int p = 0; p < `NOC_PORTS; p++) begin
                wr_ptr[p] <= wr_ptr[p] + PTRW'(in_send[p]);
                rd_ptr[p] <= rd_ptr[p] + PTRW'(pop[p]);
                count[p]  <= count[p] + CNTW'(in_send[p]) - CNTW'(pop[p]);
                credit[p] <= credit[p] - CNTW'(gnt_any[p]) + CNTW'(out_credit[p]);
                if (gnt_any[p]) begin
                    last_gnt[p] <= gnt_src[p];
                end
            end
            out_send  <= gnt_any;
            // Slot freed on the same edge the flit leaves
            in_credit <= pop;
        end
    end

    for (genvar p = 0; p < `NOC_PORTS; p++) begin : g_chk
        a_no_overflow: assert property (@(posedge clk) disable iff (reset)
            in_send[p] |-> count[p] != CNTW'(`NOC_BUF_DEPTH));
        // A receiver returns no credit while all of them are home
        a_no_extra_credit: assert property (@(posedge clk) disable iff (reset)
            out_credit[p] |-> credit[p] != CNTW'(`NOC_BUF_DEPTH));
    end

endmodule

//--- hw/noc_star.sv
`include "noc_cfg.svh"

module noc_star (
    input  logic                clk,
    input  logic                reset,

    input  logic                s_tvalid,
    output logic                s_tready,
    input  noc_pkg::payload_u   s_tdata,
    input  noc_pkg::flit_dest_t s_tdest,
    input  noc_pkg::op_e        s_tuser,

    output logic                m_tvalid,
    input  logic                m_tready,
    output noc_pkg::payload_u   m_tdata,
    output noc_pkg::flit_dest_t m_tdest,
    output noc_pkg::op_e        m_tuser
);
    import noc_pkg::*;

    // Router side links, index is the router port
    payload_u   [`NOC_PORTS-1:0] rin_data;
    flit_dest_t [`NOC_PORTS-1:0] rin_dest;
    op_e        [`NOC_PORTS-1:0] rin_op;
    logic       [`NOC_PORTS-1:0] rin_send;
    logic       [`NOC_PORTS-1:0] rin_credit;
    payload_u   [`NOC_PORTS-1:0] rout_data;
    op_e        [`NOC_PORTS-1:0] rout_op;
    logic       [`NOC_PORTS-1:0] rout_send;
    logic       [`NOC_PORTS-1:0] rout_credit;
    flit_dest_t [`NOC_PORTS-1:0] rout_src;

    // ------------------------------
    // Host side
    // ------------------------------
    noc_ingress u_ingress (
        .clk(clk), .reset(reset),
        .s_tvalid(s_tvalid), .s_tready(s_tready), .s_tdata(s_tdata),
        .s_tdest(s_tdest), .s_tuser(s_tuser),
        .flit_data(rin_data[0]), .flit_dest(rin_dest[0]), .flit_op(rin_op[0]),
        .flit_send(rin_send[0]), .flit_credit(rin_credit[0])
    );

    noc_egress u_egress (
        .clk(clk), .reset(reset),
        .flit_data(rout_data[0]), .flit_src(rout_src[0]), .flit_op(rout_op[0]),
        .flit_send(rout_send[0]), .flit_credit(rout_credit[0]),
        .m_tvalid(m_tvalid), .m_tready(m_tready), .m_tdata(m_tdata),
        .m_tdest(m_tdest), .m_tuser(m_tuser)
    );

    // Elements take no dest, so out_dest stays open
    noc_router u_router (
        .clk(clk), .reset(reset),
        .in_data(rin_data), .in_dest(rin_dest), .in_op(rin_op),
        .in_send(rin_send), .in_credit(rin_credit),
        .out_data(rout_data), .out_dest(), .out_op(rout_op),
        .out_send(rout_send), .out_credit(rout_credit), .out_src(rout_src)
    );

    // ------------------------------
    // Processing elements
    // ------------------------------
    noc_pe u_pe1 (
        .clk(clk), .reset(reset),
        .in_data(rout_data[1]), .in_op(rout_op[1]),
        .in_send(rout_send[1]), .in_credit(rout_credit[1]),
        .out_data(rin_data[1]), .out_dest(rin_dest[1]), .out_op(rin_op[1]),
        .out_send(rin_send[1]), .out_credit(rin_credit[1])
    );

    noc_pe u_pe2 (
        .clk(clk), .reset(reset),
        .in_data(rout_data[2]), .in_op(rout_op[2]),
        .in_send(rout_send[2]), .in_credit(rout_credit[2]),
        .out_data(rin_data[2]), .out_dest(rin_dest[2]), .out_op(rin_op[2]),
        .out_send(rin_send[2]), .out_credit(rin_credit[2])
    );

    noc_pe u_pe3 (
        .clk(clk), .reset(reset),
        .in_data(rout_data[3]), .in_op(rout_op[3]),
        .in_send(rout_send[3]), .in_credit(rout_credit[3]),
        .out_data(rin_data[3]), .out_dest(rin_dest[3]), .out_op(rin_op[3]),
        .out_send(rin_send[3]), .out_credit(rin_credit[3])
    );

    noc_pe u_pe4 (
        .clk(clk), .reset(reset),
        .in_data(rout_data[4]), .in_op(rout_op[4]),
        .in_send(rout_send[4]), .in_credit(rout_credit[4]),
        .out_data(rin_data[4]), .out_dest(rin_dest[4]), .out_op(rin_op[4]),
        .out_send(rin_send[4]), .out_credit(rin_credit[4])
    );

endmodule

//--- tests/noc_star_tb.sv
`include "noc_cfg.svh"

module noc_star_tb;
    import noc_pkg::*;

    localparam int NUM_WORDS       = 400;
    localparam int WATCHDOG_CYCLES = NUM_WORDS * 40 + 1000;

    logic       clk;
    logic       reset;
    logic       s_tvalid;
    logic       s_tready;
    payload_u   s_tdata;
    flit_dest_t s_tdest;
    op_e        s_tuser;
    logic       m_tvalid;
    logic       m_tready;
    payload_u   m_tdata;
    flit_dest_t m_tdest;
    op_e        m_tuser;

    // Expected results of each element, indexed by router port
    payload_u   exp_data [`NOC_PORTS][$];
    op_e        exp_op   [`NOC_PORTS][$];
    int         acc_model [`NOC_PORTS];

    integer      seed;
    logic [31:0] r;
    int          accepted;
    int          received;
    int          e;
    logic        stall_prev;
    payload_u    data_prev;
    flit_dest_t  dest_prev;
    op_e         op_prev;

    noc_star u_dut (
        .clk(clk), .reset(reset),
        .s_tvalid(s_tvalid), .s_tready(s_tready), .s_tdata(s_tdata),
        .s_tdest(s_tdest), .s_tuser(s_tuser),
        .m_tvalid(m_tvalid), .m_tready(m_tready), .m_tdata(m_tdata),
        .m_tdest(m_tdest), .m_tuser(m_tuser)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ------------------------------
    // Failure and compare tasks
    // ------------------------------
    task automatic abort_run();
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_payload(string name, payload_u exp, payload_u act);
        if (act !== exp) begin
            $display("ERR time=%0t %s expected=%h actual=%h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_dest(string name, flit_dest_t exp, flit_dest_t act);
        if (act !== exp) begin
            $display("ERR time=%0t %s expected=%0d actual=%0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_op(string name, op_e exp, op_e act);
        if (act !== exp) begin
            $display("ERR time=%0t %s expected=%0d actual=%0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("ERR time=%0t %s expected=%b actual=%b", $time, name, exp, act);
            abort_run();
        end
    endtask

    // Reference behavior of one element for one accepted host word
    task automatic predict(payload_u d, flit_dest_t dest, op_e op);
        payload_u res;
        int       lane_val;
        int       idx;
        idx = int'(dest);
        res = d;
        case (op)
            op_relu: begin
                for (int l = 0; l < `NOC_LANES; l++) begin
                    if ($signed(d.lanes[l]) < 0) begin
                        res.lanes[l] = '0;
                    end
                end
            end
            op_acc: begin
                for (int l = 0; l < `NOC_LANES; l++) begin
                    lane_val = $signed(d.lanes[l]);
                    acc_model[idx] = acc_model[idx] + lane_val;
                end
                res.word = acc_model[idx];
            end
            default: res = d;
        endcase
        exp_data[idx].push_back(res);
        exp_op[idx].push_back(op);
    endtask

    // ------------------------------
    // Stimulus and checking
    // ------------------------------
    initial begin
        seed       = 32'h88ba9ce6;
        reset      = 1'b1;
        s_tvalid   = 1'b0;
        s_tdata    = '0;
        s_tdest    = '0;
        s_tuser    = op_pass;
        m_tready   = 1'b0;
        accepted   = 0;
        received   = 0;
        stall_prev = 1'b0;
        data_prev  = '0;
        dest_prev  = '0;
        op_prev    = op_pass;
        for (int p = 0; p < `NOC_PORTS; p++) begin
            acc_model[p] = 0;
        end

        // First edge still sees unreset state
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            if (i > 0) begin
                check_flag("m_tvalid", 1'b0, m_tvalid);
            end
        end
        reset <= 1'b0;
        @(posedge clk);
        @(posedge clk);
        check_flag("s_tready", 1'b1, s_tready);

        while (!(accepted == NUM_WORDS && received == NUM_WORDS)) begin
            @(posedge clk);

            // Output must hold while stalled
            if (stall_prev) begin
                check_flag("m_tvalid", 1'b1, m_tvalid);
                check_payload("m_tdata", data_prev, m_tdata);
                check_dest("m_tdest", dest_prev, m_tdest);
                check_op("m_tuser", op_prev, m_tuser);
            end
            stall_prev = m_tvalid && !m_tready;
            data_prev  = m_tdata;
            dest_prev  = m_tdest;
            op_prev    = m_tuser;

            if (m_tvalid && m_tready) begin
                e = int'(m_tdest);
                if (e < 1 || e >= `NOC_PORTS) begin
                    $display("Result tagged with unknown element %0d at time %0t", e, $time);
                    abort_run();
                end
                if (exp_data[e].size() == 0) begin
                    $display("Unexpected result from element %0d at time %0t", e, $time);
                    abort_run();
                end
                check_payload("m_tdata", exp_data[e].pop_front(), m_tdata);
                check_op("m_tuser", exp_op[e].pop_front(), m_tuser);
                received++;
            end

            if (s_tvalid && s_tready) begin
                predict(s_tdata, s_tdest, s_tuser);
                accepted++;
            end

            // New word only once the last one is gone
            if (!s_tvalid || s_tready) begin
                if (accepted < NUM_WORDS) begin
                    r = $random(seed);
                    s_tvalid <= r[1:0] != 2'd0;
                    s_tdest  <= flit_dest_t'({1'b0, r[5:4]} + 3'd1);
                    s_tuser  <= op_e'(r[7:6]);
                    s_tdata  <= $random(seed);
                end else begin
                    s_tvalid <= 1'b0;
                end
            end

            r = $random(seed);
            m_tready <= r[1:0] != 2'd0;
        end

        // Every result is back, so nothing may wait at the output
        @(posedge clk);
        if (m_tvalid !== 1'b0) begin
            $display("Extra result waiting at the output at time %0t", $time);
            abort_run();
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, %0d of %0d results received",
                 WATCHDOG_CYCLES, received, NUM_WORDS);
        abort_run();
    end

endmodule
